// File: hdl/rvseed_pkg.sv
// rvseed shared types and encodings
package rvseed_pkg;

    typedef logic [31:0] xlen_t;      // one data word
    typedef logic [4:0]  reg_addr_t;  // register index

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B   // lui
    } alu_op_e;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    localparam xlen_t ADDR_PUSH   = 32'h0000_0000;  // write only
    localparam xlen_t ADDR_STATUS = 32'h0000_0004;  // read only, fill count
    localparam xlen_t RESET_PC    = 32'h8000_0000;

    typedef struct packed {
        xlen_t       pc;
        logic [31:0] inst;
    } fetch_t;

    typedef struct packed {
        logic      valid;
        xlen_t     pc;
        xlen_t     src1;
        xlen_t     src2;
        alu_op_e   alu_op;
        reg_addr_t rd;
        logic      reg_wen;
        logic      unknown;
    } id_ex_t;

    typedef struct packed {
        logic      valid;
        xlen_t     pc;
        reg_addr_t rd;
        logic      reg_wen;
        xlen_t     result;
        logic      unknown;
    } ex_wb_t;

    typedef struct packed {
        xlen_t     pc;
        reg_addr_t rd;
        xlen_t     wdata;
        logic      unknown;
    } retire_t;

endpackage

// File: hdl/inst_queue_apb.sv
// apb instruction queue
`timescale 1ns/100ps
module inst_queue_apb #(
    parameter int DEPTH = 8
) (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                psel_i,
    input  logic                penable_i,
    input  logic                pwrite_i,
    input  rvseed_pkg::xlen_t   paddr_i,
    input  rvseed_pkg::xlen_t   pwdata_i,
    output rvseed_pkg::xlen_t   prdata_o,
    output logic                pready_o,
    output logic                pslverr_o,
    output logic                fetch_valid_o,
    output rvseed_pkg::fetch_t  fetch_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [31:0]       fifo_mem [DEPTH];
    logic [PTR_W-1:0]  wr_ptr_q;
    logic [PTR_W-1:0]  rd_ptr_q;
    logic [CNT_W-1:0]  count_q;
    rvseed_pkg::xlen_t pc_q;
    logic              hit_push;
    logic              hit_status;
    logic              full;
    logic              empty;
    logic              push;
    logic              pop;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;  // wraps for any depth
    endfunction

    assign hit_push   = (paddr_i == rvseed_pkg::ADDR_PUSH);
    assign hit_status = (paddr_i == rvseed_pkg::ADDR_STATUS);
    assign full       = (count_q == CNT_W'(DEPTH));
    assign empty      = (count_q == '0);
    assign pop        = !empty;  // decode drains one word per cycle
    assign push       = psel_i && penable_i && pwrite_i && hit_push && !full;

    // wait states only for a push into a full queue
    assign pready_o  = !(psel_i && pwrite_i && hit_push && full);
    assign pslverr_o = psel_i && penable_i &&
                       !((pwrite_i && hit_push) || (!pwrite_i && hit_status));
    assign prdata_o  = (psel_i && !pwrite_i && hit_status) ?
                       {{(32 - CNT_W){1'b0}}, count_q} : '0;

    assign fetch_valid_o = pop;
    assign fetch_o.pc    = pc_q;
    assign fetch_o.inst  = fifo_mem[rd_ptr_q];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            pc_q     <= rvseed_pkg::RESET_PC;
        end else begin
            if (push) begin
                wr_ptr_q <= ptr_next(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= ptr_next(rd_ptr_q);
                pc_q     <= pc_q + 32'd4;  // pc follows pop order
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_ptr_q] <= pwdata_i;
        end
    end

    // a held-off push leaves only the pop, so one slot frees up
    assert property (@(posedge clk) disable iff (!rst_n_i)
        (psel_i && penable_i && pwrite_i && hit_push && full) |=>
            (count_q == CNT_W'(DEPTH - 1)))
        else $error("push accepted while queue full");

endmodule

// File: hdl/regfile.sv
// integer register file
`timescale 1ns/100ps
module regfile (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  rvseed_pkg::reg_addr_t raddr1_i,
    input  rvseed_pkg::reg_addr_t raddr2_i,
    output rvseed_pkg::xlen_t     rdata1_o,
    output rvseed_pkg::xlen_t     rdata2_o,
    input  logic                  wen_i,
    input  rvseed_pkg::reg_addr_t waddr_i,
    input  rvseed_pkg::xlen_t     wdata_i
);

    rvseed_pkg::xlen_t regs_q [1:31];  // x0 has no storage

    assign rdata1_o = (raddr1_i == '0) ? '0 : regs_q[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs_q[raddr2_i];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wen_i && waddr_i != '0) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

endmodule

// File: hdl/id_stage.sv
// decode and operand forwarding
`timescale 1ns/100ps
module id_stage (
    input  logic                  fetch_valid_i,
    input  rvseed_pkg::fetch_t    fetch_i,
    input  rvseed_pkg::xlen_t     rdata1_i,
    input  rvseed_pkg::xlen_t     rdata2_i,
    output rvseed_pkg::reg_addr_t raddr1_o,
    output rvseed_pkg::reg_addr_t raddr2_o,
    input  rvseed_pkg::ex_wb_t    ex_fwd_i,
    input  rvseed_pkg::ex_wb_t    wb_fwd_i,
    output rvseed_pkg::id_ex_t    id_ex_o
);

    localparam logic [6:0] F7_ZERO = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;  // sub and sra

    logic [31:0]         inst;
    logic [6:0]          opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    rvseed_pkg::xlen_t   imm_i;
    rvseed_pkg::xlen_t   imm_u;
    rvseed_pkg::xlen_t   imm;
    rvseed_pkg::xlen_t   rs1_val;
    rvseed_pkg::xlen_t   rs2_val;
    rvseed_pkg::alu_op_e alu_op;
    logic                use_imm;
    logic                legal;

    function automatic rvseed_pkg::alu_op_e funct3_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? rvseed_pkg::ALU_SUB : rvseed_pkg::ALU_ADD;
            3'b001:  return rvseed_pkg::ALU_SLL;
            3'b010:  return rvseed_pkg::ALU_SLT;
            3'b011:  return rvseed_pkg::ALU_SLTU;
            3'b100:  return rvseed_pkg::ALU_XOR;
            3'b101:  return alt ? rvseed_pkg::ALU_SRA : rvseed_pkg::ALU_SRL;
            3'b110:  return rvseed_pkg::ALU_OR;
            default: return rvseed_pkg::ALU_AND;
        endcase
    endfunction

    // newest producer wins, x0 never forwarded
    function automatic rvseed_pkg::xlen_t fwd_sel(input rvseed_pkg::reg_addr_t rs,
                                                  input rvseed_pkg::xlen_t rf_val,
                                                  input rvseed_pkg::ex_wb_t ex_f,
                                                  input rvseed_pkg::ex_wb_t wb_f);
        if (rs != '0 && ex_f.valid && ex_f.reg_wen && ex_f.rd == rs) begin
            return ex_f.result;
        end
        if (rs != '0 && wb_f.valid && wb_f.reg_wen && wb_f.rd == rs) begin
            return wb_f.result;
        end
        return rf_val;
    endfunction

    assign inst     = fetch_i.inst;
    assign opcode   = inst[6:0];
    assign funct3   = inst[14:12];
    assign funct7   = inst[31:25];
    assign imm_i    = {{20{inst[31]}}, inst[31:20]};
    assign imm_u    = {inst[31:12], 12'b0};
    assign raddr1_o = inst[19:15];
    assign raddr2_o = inst[24:20];
    assign rs1_val  = fwd_sel(raddr1_o, rdata1_i, ex_fwd_i, wb_fwd_i);
    assign rs2_val  = fwd_sel(raddr2_o, rdata2_i, ex_fwd_i, wb_fwd_i);

    always_comb begin
        alu_op  = rvseed_pkg::ALU_ADD;
        use_imm = 1'b0;
        imm     = imm_i;
        legal   = 1'b1;
        case (opcode)
            rvseed_pkg::OPC_OP: begin
                alu_op = funct3_op(funct3, funct7[5]);
                legal  = (funct7 == F7_ZERO) ||
                         (funct7 == F7_ALT && (funct3 == 3'b000 || funct3 == 3'b101));
            end
            rvseed_pkg::OPC_OP_IMM: begin
                use_imm = 1'b1;
                alu_op  = funct3_op(funct3, funct3 == 3'b101 && funct7[5]);  // addi never subs
                if (funct3 == 3'b001) begin
                    legal = (funct7 == F7_ZERO);
                end else if (funct3 == 3'b101) begin
                    legal = (funct7 == F7_ZERO) || (funct7 == F7_ALT);
                end
            end
            rvseed_pkg::OPC_LUI: begin
                alu_op  = rvseed_pkg::ALU_PASS_B;
                use_imm = 1'b1;
                imm     = imm_u;
            end
            default: legal = 1'b0;
        endcase
    end

    always_comb begin
        id_ex_o.valid   = fetch_valid_i;
        id_ex_o.pc      = fetch_i.pc;
        id_ex_o.src1    = rs1_val;
        id_ex_o.src2    = use_imm ? imm : rs2_val;
        id_ex_o.alu_op  = alu_op;
        id_ex_o.rd      = inst[11:7];
        id_ex_o.reg_wen = fetch_valid_i && legal;
        id_ex_o.unknown = fetch_valid_i && !legal;  // retires, writes nothing
    end

endmodule

// File: hdl/pipe_reg.sv
// generic pipeline stage register
`timescale 1ns/100ps
module pipe_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     rst_n_i,
    input  payload_t d_i,
    output payload_t q_o
);

    payload_t q_q;

    assign q_o = q_q;

    // all zeros is a bubble, valid bit low
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            q_q <= '0;
        end else begin
            q_q <= d_i;
        end
    end

endmodule

// File: hdl/ex_stage.sv
// execute stage alu
`timescale 1ns/100ps
module ex_stage (
    input  rvseed_pkg::id_ex_t id_ex_i,
    output rvseed_pkg::ex_wb_t ex_wb_o
);

    rvseed_pkg::xlen_t a;
    rvseed_pkg::xlen_t b;
    rvseed_pkg::xlen_t result;
    logic [4:0]        shamt;

    assign a     = id_ex_i.src1;
    assign b     = id_ex_i.src2;
    assign shamt = b[4:0];  // low five bits only

    always_comb begin
        case (id_ex_i.alu_op)
            rvseed_pkg::ALU_ADD:    result = a + b;
            rvseed_pkg::ALU_SUB:    result = a - b;
            rvseed_pkg::ALU_SLL:    result = a << shamt;
            rvseed_pkg::ALU_SLT:    result = {31'b0, $signed(a) < $signed(b)};
            rvseed_pkg::ALU_SLTU:   result = {31'b0, a < b};
            rvseed_pkg::ALU_XOR:    result = a ^ b;
            rvseed_pkg::ALU_SRL:    result = a >> shamt;
            rvseed_pkg::ALU_SRA:    result = $unsigned($signed(a) >>> shamt);
            rvseed_pkg::ALU_OR:     result = a | b;
            rvseed_pkg::ALU_AND:    result = a & b;
            rvseed_pkg::ALU_PASS_B: result = b;  // lui
            default:                result = '0;
        endcase
    end

    always_comb begin
        ex_wb_o.valid   = id_ex_i.valid;
        ex_wb_o.pc      = id_ex_i.pc;
        ex_wb_o.rd      = id_ex_i.rd;
        ex_wb_o.reg_wen = id_ex_i.reg_wen;
        ex_wb_o.result  = result;
        ex_wb_o.unknown = id_ex_i.unknown;
    end

endmodule

// File: hdl/wb_stage.sv
// write-back and retire port
`timescale 1ns/100ps
module wb_stage (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  rvseed_pkg::ex_wb_t    ex_wb_i,
    output logic                  wen_o,
    output rvseed_pkg::reg_addr_t waddr_o,
    output rvseed_pkg::xlen_t     wdata_o,
    output logic                  retire_valid_o,
    output rvseed_pkg::retire_t   retire_o
);

    logic                retire_valid_q;
    rvseed_pkg::retire_t retire_q;
    logic                x0_write;

    assign wen_o    = ex_wb_i.valid && ex_wb_i.reg_wen;
    assign waddr_o  = ex_wb_i.rd;
    assign wdata_o  = ex_wb_i.result;
    assign x0_write = wen_o && (ex_wb_i.rd == '0);

    assign retire_valid_o = retire_valid_q;
    assign retire_o       = retire_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            retire_valid_q <= 1'b0;
        end else begin
            retire_valid_q <= ex_wb_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        retire_q.pc      <= ex_wb_i.pc;
        retire_q.rd      <= ex_wb_i.rd;
        retire_q.wdata   <= (wen_o && !x0_write) ? ex_wb_i.result : '0;  // what rd now holds
        retire_q.unknown <= ex_wb_i.unknown;
    end

    // a retired x0 target always reports zero
    assert property (@(posedge clk) disable iff (!rst_n_i)
        (retire_valid_o && retire_o.rd == '0) |-> (retire_o.wdata == '0))
        else $error("nonzero wdata retired for x0");

endmodule

// File: hdl/rvseed_core.sv
// rvseed three stage core top
`timescale 1ns/100ps
module rvseed_core #(
    parameter int DEPTH = 8
) (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                psel_i,
    input  logic                penable_i,
    input  logic                pwrite_i,
    input  rvseed_pkg::xlen_t   paddr_i,
    input  rvseed_pkg::xlen_t   pwdata_i,
    output rvseed_pkg::xlen_t   prdata_o,
    output logic                pready_o,
    output logic                pslverr_o,
    output logic                retire_valid_o,
    output rvseed_pkg::retire_t retire_o
);

    logic                  fetch_valid;
    rvseed_pkg::fetch_t    fetch;
    rvseed_pkg::reg_addr_t raddr1;
    rvseed_pkg::reg_addr_t raddr2;
    rvseed_pkg::xlen_t     rdata1;
    rvseed_pkg::xlen_t     rdata2;
    rvseed_pkg::id_ex_t    id_ex_d;
    rvseed_pkg::id_ex_t    id_ex_q;
    rvseed_pkg::ex_wb_t    ex_wb_d;   // also the execute forward path
    rvseed_pkg::ex_wb_t    ex_wb_q;   // also the write-back forward path
    logic                  rf_wen;
    rvseed_pkg::reg_addr_t rf_waddr;
    rvseed_pkg::xlen_t     rf_wdata;

    inst_queue_apb #(.DEPTH(DEPTH)) u_inst_queue (
        .clk(clk),
        .rst_n_i(rst_n_i),
        .psel_i(psel_i),
        .penable_i(penable_i),
        .pwrite_i(pwrite_i),
        .paddr_i(paddr_i),
        .pwdata_i(pwdata_i),
        .prdata_o(prdata_o),
        .pready_o(pready_o),
        .pslverr_o(pslverr_o),
        .fetch_valid_o(fetch_valid),
        .fetch_o(fetch)
    );

    id_stage u_id_stage (
        .fetch_valid_i(fetch_valid),
        .fetch_i(fetch),
        .rdata1_i(rdata1),
        .rdata2_i(rdata2),
        .raddr1_o(raddr1),
        .raddr2_o(raddr2),
        .ex_fwd_i(ex_wb_d),
        .wb_fwd_i(ex_wb_q),
        .id_ex_o(id_ex_d)
    );

    regfile u_regfile (
        .clk(clk),
        .rst_n_i(rst_n_i),
        .raddr1_i(raddr1),
        .raddr2_i(raddr2),
        .rdata1_o(rdata1),
        .rdata2_o(rdata2),
        .wen_i(rf_wen),
        .waddr_i(rf_waddr),
        .wdata_i(rf_wdata)
    );

    pipe_reg #(.payload_t(rvseed_pkg::id_ex_t)) u_id_ex_reg (
        .clk(clk),
        .rst_n_i(rst_n_i),
        .d_i(id_ex_d),
        .q_o(id_ex_q)
    );

    ex_stage u_ex_stage (
        .id_ex_i(id_ex_q),
        .ex_wb_o(ex_wb_d)
    );

    pipe_reg #(.payload_t(rvseed_pkg::ex_wb_t)) u_ex_wb_reg (
        .clk(clk),
        .rst_n_i(rst_n_i),
        .d_i(ex_wb_d),
        .q_o(ex_wb_q)
    );

    wb_stage u_wb_stage (
        .clk(clk),
        .rst_n_i(rst_n_i),
        .ex_wb_i(ex_wb_q),
        .wen_o(rf_wen),
        .waddr_o(rf_waddr),
        .wdata_o(rf_wdata),
        .retire_valid_o(retire_valid_o),
        .retire_o(retire_o)
    );

endmodule

// File: tests/clk_gen.sv
// testbench clock and reset
`timescale 1ns/100ps
module clk_gen #(
    parameter real PERIOD       = 8.0,
    parameter int  RESET_CYCLES = 10
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2.0) clk_o = ~clk_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;  // release away from the active edge
    end

endmodule

// File: tests/rvseed_core_tb.sv
// rvseed core testbench
`timescale 1ns/100ps
module rvseed_core_tb;

    localparam int DEPTH  = 1;   // single entry so the queue is full between pushes
    localparam int N_RAND = 40;

    typedef struct packed {
        logic [31:0]           inst;
        rvseed_pkg::reg_addr_t rd;
        rvseed_pkg::xlen_t     wdata;
        logic                  unknown;
    } stim_t;

    logic                clk;
    logic                rst_n;
    logic                psel;
    logic                penable;
    logic                pwrite;
    rvseed_pkg::xlen_t   paddr;
    rvseed_pkg::xlen_t   pwdata;
    rvseed_pkg::xlen_t   prdata_o;
    logic                pready_o;
    logic                pslverr_o;
    logic                retire_valid_o;
    rvseed_pkg::retire_t retire_o;

    stim_t             stim_q[$];       // instruction and expected retire record
    int                push_cycle_q[$]; // cycle of each accepted push
    rvseed_pkg::xlen_t model_regs [32];
    logic [31:0]       lcg_state;
    int                cycle_cnt = 0;
    int                cycle_limit = 200;
    int                retire_cnt = 0;
    logic              pready_low_seen = 1'b0;

    clk_gen #(.PERIOD(8.0), .RESET_CYCLES(10)) u_clk_gen (
        .clk_o(clk),
        .rst_n_o(rst_n)
    );

    rvseed_core #(.DEPTH(DEPTH)) rvseed_core_inst (
        .clk(clk),
        .rst_n_i(rst_n),
        .psel_i(psel),
        .penable_i(penable),
        .pwrite_i(pwrite),
        .paddr_i(paddr),
        .pwdata_i(pwdata),
        .prdata_o(prdata_o),
        .pready_o(pready_o),
        .pslverr_o(pslverr_o),
        .retire_valid_o(retire_valid_o),
        .retire_o(retire_o)
    );

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_value_error(input string name, input logic [31:0] got,
                                      input logic [31:0] want);
        $display("ERR %s: got 0x%08h, expected 0x%08h", name, got, want);
        abort_run();
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        abort_run();
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, rvseed_pkg::OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, rvseed_pkg::OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, rvseed_pkg::OPC_LUI};
    endfunction

    // architectural model, updates model_regs in program order
    function automatic stim_t predict(input logic [31:0] inst);
        stim_t             s;
        logic [6:0]        op;
        logic [2:0]        f3;
        logic [6:0]        f7;
        rvseed_pkg::xlen_t a;
        rvseed_pkg::xlen_t b;
        rvseed_pkg::xlen_t val;
        logic              ok;
        op  = inst[6:0];
        f3  = inst[14:12];
        f7  = inst[31:25];
        a   = model_regs[inst[19:15]];
        val = '0;
        ok  = 1'b1;
        if (op == rvseed_pkg::OPC_LUI) begin
            val = {inst[31:12], 12'h000};
        end else if (op == rvseed_pkg::OPC_OP || op == rvseed_pkg::OPC_OP_IMM) begin
            b = (op == rvseed_pkg::OPC_OP) ? model_regs[inst[24:20]] :
                {{20{inst[31]}}, inst[31:20]};
            if (op == rvseed_pkg::OPC_OP) begin
                ok = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
            end else if (f3 == 3'd1) begin
                ok = (f7 == 7'h00);
            end else if (f3 == 3'd5) begin
                ok = (f7 == 7'h00) || (f7 == 7'h20);
            end
            case (f3)
                3'd0: val = (op == rvseed_pkg::OPC_OP && f7[5]) ? a - b : a + b;
                3'd1: val = a << b[4:0];
                3'd2: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                3'd3: val = (a < b) ? 32'd1 : 32'd0;
                3'd4: val = a ^ b;
                3'd5: val = f7[5] ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
                3'd6: val = a | b;
                default: val = a & b;
            endcase
        end else begin
            ok = 1'b0;
        end
        s.inst    = inst;
        s.rd      = inst[11:7];
        s.unknown = !ok;
        s.wdata   = (ok && s.rd != '0) ? val : '0;
        if (ok && s.rd != '0) begin
            model_regs[s.rd] = val;
        end
        return s;
    endfunction

    task automatic build_program();
        logic [31:0] prog[$];
        logic [31:0] r1;
        logic [31:0] r2;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [11:0] imm;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        prog = '{enc_i(12'd5, 0, 3'd0, 1), enc_i(12'hffd, 0, 3'd0, 2),
                 enc_r(7'h00, 2, 1, 3'd0, 3), enc_r(7'h20, 1, 3, 3'd0, 4),
                 enc_r(7'h00, 2, 1, 3'd1, 5), enc_r(7'h00, 1, 2, 3'd2, 6),
                 enc_r(7'h00, 1, 2, 3'd3, 7), enc_r(7'h00, 2, 4, 3'd4, 8),
                 enc_r(7'h00, 1, 2, 3'd5, 9), enc_r(7'h20, 1, 2, 3'd5, 10),
                 enc_r(7'h00, 9, 8, 3'd6, 11), enc_r(7'h00, 10, 11, 3'd7, 12),
                 enc_i(12'd31, 1, 3'd1, 13), enc_i(12'd4, 2, 3'd5, 14),
                 enc_i({7'h20, 5'd4}, 2, 3'd5, 15), enc_i(12'hfff, 2, 3'd2, 16),
                 enc_i(12'hfff, 1, 3'd3, 17), enc_i(12'hfff, 1, 3'd4, 18),
                 enc_i(12'h0f0, 1, 3'd6, 19), enc_i(12'h7f0, 2, 3'd7, 20),
                 enc_u(20'h80001, 21), enc_i(12'hfff, 21, 3'd0, 21),
                 enc_i(12'd7, 1, 3'd0, 0), enc_r(7'h00, 1, 0, 3'd0, 22),
                 32'hffff_ffff, enc_r(7'h00, 1, 31, 3'd0, 23),
                 enc_r(7'h01, 2, 1, 3'd0, 24), enc_i({7'h20, 5'd3}, 1, 3'd1, 25),
                 enc_r(7'h00, 1, 24, 3'd0, 24), enc_i(12'd9, 0, 3'd0, 26),
                 enc_i(12'd1, 0, 3'd0, 27), enc_i(12'd2, 0, 3'd0, 28),
                 enc_r(7'h00, 26, 26, 3'd0, 29)};
        lcg_state = 32'h64e5;
        for (int i = 0; i < N_RAND; i++) begin
            lcg_state = lcg_next(lcg_state);
            r1        = lcg_state;
            lcg_state = lcg_next(lcg_state);
            r2        = lcg_state;
            rd  = {2'b00, r1[30:28]};  // x0..x7 keeps dependencies close
            rs1 = {2'b00, r1[27:25]};
            rs2 = {2'b00, r1[24:22]};
            f3  = r1[21:19];
            imm = r2[31:20];
            case (r1[17:16])
                2'b00: prog.push_back(enc_r((r1[18] && (f3 == 3'd0 || f3 == 3'd5)) ?
                                            7'h20 : 7'h00, rs2, rs1, f3, rd));
                2'b11: prog.push_back(enc_u(r2[31:12], rd));
                default: begin
                    if (f3 == 3'd1) begin
                        imm[11:5] = 7'h00;
                    end else if (f3 == 3'd5) begin
                        imm[11:5] = r1[18] ? 7'h20 : 7'h00;
                    end
                    prog.push_back(enc_i(imm, rs1, f3, rd));
                end
            endcase
        end
        foreach (prog[i]) begin
            stim_q.push_back(predict(prog[i]));
        end
    endtask

    // one apb transfer, setup then access, waits on pready_o
    task automatic apb_access(input logic write, input rvseed_pkg::xlen_t addr,
                              input rvseed_pkg::xlen_t wdata,
                              output rvseed_pkg::xlen_t rdata, output logic slverr);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        @(posedge clk);
        while (!pready_o) @(posedge clk);
        rdata  = prdata_o;
        slverr = pslverr_o;
        if (write && addr == rvseed_pkg::ADDR_PUSH && !pslverr_o) begin
            push_cycle_q.push_back(cycle_cnt);
        end
    endtask

    task automatic apb_idle();
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) begin
            $display("timeout after %0d cycles, %0d of %0d instructions retired",
                     cycle_cnt, retire_cnt, stim_q.size());
            abort_run();
        end
    end

    always @(posedge clk) begin
        if (psel && !pready_o) begin
            pready_low_seen <= 1'b1;
        end
    end

    always @(posedge clk) begin : retire_check
        stim_t             want;
        rvseed_pkg::xlen_t want_pc;
        int                push_cycle;
        if (rst_n && retire_valid_o) begin
            assert (retire_cnt < stim_q.size())
                else report_failure("retire seen after the whole program had retired");
            want       = stim_q[retire_cnt];
            want_pc    = rvseed_pkg::RESET_PC + 32'(4 * retire_cnt);
            push_cycle = push_cycle_q.pop_front();
            assert (retire_o.pc == want_pc)
                else report_value_error("retire_o.pc", retire_o.pc, want_pc);
            assert (retire_o.rd == want.rd)
                else report_value_error("retire_o.rd", 32'(retire_o.rd), 32'(want.rd));
            assert (retire_o.wdata == want.wdata)
                else report_value_error("retire_o.wdata", retire_o.wdata, want.wdata);
            assert (retire_o.unknown == want.unknown)
                else report_value_error("retire_o.unknown", 32'(retire_o.unknown),
                                        32'(want.unknown));
            assert (cycle_cnt == push_cycle + 4)  // push edge to retire sample
                else report_value_error("retire latency", 32'(cycle_cnt - push_cycle), 32'd4);
            retire_cnt <= retire_cnt + 1;
        end
    end

    initial begin
        rvseed_pkg::xlen_t rdata;
        logic              err;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        build_program();
        cycle_limit = 20 * stim_q.size() + 200;
        @(posedge rst_n);
        @(posedge clk);
        assert (!retire_valid_o)
            else report_value_error("retire_valid_o", 32'(retire_valid_o), 32'd0);
        apb_access(1'b0, rvseed_pkg::ADDR_STATUS, '0, rdata, err);
        assert (rdata == '0) else report_value_error("prdata_o", rdata, 32'd0);
        assert (!err) else report_value_error("pslverr_o", 32'(err), 32'd0);

        // back to back pushes, bad accesses in the middle
        foreach (stim_q[i]) begin
            apb_access(1'b1, rvseed_pkg::ADDR_PUSH, stim_q[i].inst, rdata, err);
            assert (!err) else report_value_error("pslverr_o", 32'(err), 32'd0);
            if (i == stim_q.size() / 2) begin
                apb_access(1'b0, rvseed_pkg::ADDR_PUSH, '0, rdata, err);
                assert (err) else report_value_error("pslverr_o", 32'(err), 32'd1);
                apb_access(1'b1, rvseed_pkg::ADDR_STATUS, 32'h0000_0013, rdata, err);
                assert (err) else report_value_error("pslverr_o", 32'(err), 32'd1);
            end
        end
        apb_idle();

        while (retire_cnt < stim_q.size()) @(posedge clk);
        repeat (8) @(posedge clk);  // nothing extra may retire
        assert (retire_cnt == stim_q.size())
            else report_value_error("retire count", 32'(retire_cnt), 32'(stim_q.size()));
        assert (pready_low_seen) else report_failure("pready_o never went low");
        $display("TEST PASSED");
        $finish;
    end

endmodule

// File: rvseed_core.f
hdl/rvseed_pkg.sv
hdl/inst_queue_apb.sv
hdl/regfile.sv
hdl/id_stage.sv
hdl/pipe_reg.sv
hdl/ex_stage.sv
hdl/wb_stage.sv
hdl/rvseed_core.sv
tests/clk_gen.sv
tests/rvseed_core_tb.sv
